// File: list.f
src/vliwPkg.sv
src/vliwIf.sv
src/instrMem.sv
src/fetchUnit.sv
src/regFile.sv
src/decodeUnit.sv
src/executeUnit.sv
src/dataMem.sv
src/vliwCore.sv
sim/tbClock.sv
sim/vliwTb.sv

// File: sim/tbClock.sv
module tbClock #(
    parameter int periodNs = 40,
    parameter int resetCycles = 16
) (
    input  logic resetReq,
    output logic clk,
    output logic rstn
);
    timeunit 1ns;
    timeprecision 100ps;

    int count;

    initial begin
        clk = 1'b0;
        forever #(periodNs / 2) clk = ~clk;
    end

    initial begin
        rstn = 1'b0;
        count = resetCycles;
    end

    // a request restarts the low phase, released after resetCycles edges
    always @(posedge clk) begin
        if (resetReq) begin
            rstn <= 1'b0;
            count <= resetCycles;
        end else if (count > 0) begin
            count <= count - 1;
            if (count == 1) begin
                rstn <= 1'b1;
            end
        end
    end

endmodule

// File: sim/vliwTb.sv
module vliwTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] idleAlu = {vliwPkg::aluNop, 26'd0};
    localparam logic [31:0] idleMem = {vliwPkg::memNop, 26'd0};

    logic clk;
    logic rstn;
    logic resetReq;
    logic run;
    logic imemWe;
    logic [7:0] imemAddr;
    logic [63:0] imemData;
    logic outValid;
    logic [31:0] outData;

    logic [63:0] prog[$];
    logic [31:0] wantOut[$];
    logic [31:0] gotOut[$];
    int errors;
    int checks;
    int tests;
    int testStartErrors;
    bit timedOut;
    integer seed;

    tbClock #(.periodNs(40), .resetCycles(16)) clockGen (
        .resetReq (resetReq),
        .clk      (clk),
        .rstn     (rstn)
    );

    vliwCore #(.imemDepth(256), .dmemDepth(256)) dut0 (
        .clk      (clk),
        .rstn     (rstn),
        .run      (run),
        .imemWe   (imemWe),
        .imemAddr (imemAddr),
        .imemData (imemData),
        .outValid (outValid),
        .outData  (outData)
    );

    function automatic logic [31:0] makeR(input logic [5:0] op, input int a, input int b,
                                          input int c);
        return {op, a[4:0], b[4:0], c[4:0], 11'd0};
    endfunction

    function automatic logic [31:0] makeI(input logic [5:0] op, input int a, input int b,
                                          input int imm);
        return {op, a[4:0], b[4:0], imm[15:0]};
    endfunction

    task automatic emit(input logic [31:0] slot1, input logic [31:0] slot0);
        prog.push_back({slot1, slot0});
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic resetCore();
        int cycles;
        resetReq = 1'b1;
        @(posedge clk);
        #2;
        resetReq = 1'b0;
        cycles = 0;
        while (rstn !== 1'b1 && cycles < 40) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (rstn !== 1'b1) begin
            $display("reset was not released within 40 cycles");
            timedOut = 1'b1;
        end
    endtask

    task automatic startTest();
        prog.delete();
        gotOut.delete();
        run = 1'b0;
        resetCore();
        testStartErrors = errors;
        tests++;
    endtask

    // halt is a jump to itself, padded with two idle bundles
    task automatic finishProgram();
        emit(idleMem, makeI(vliwPkg::aluJmp, 0, 0, prog.size()));
        emit(idleMem, idleAlu);
        emit(idleMem, idleAlu);
    endtask

    task automatic loadProgram();
        int i;
        run = 1'b0;
        for (i = 0; i < prog.size(); i++) begin
            imemWe = 1'b1;
            imemAddr = i[7:0];
            imemData = prog[i];
            @(posedge clk);
            #2;
        end
        imemWe = 1'b0;
    endtask

    // sequential model, every bundle sees all older results
    task automatic modelRun();
        logic [31:0] regs [32];
        logic [31:0] dmem [256];
        logic [31:0] s0, s1, va, vb, vBase, vData, imm0, addr, res0, res1;
        logic [4:0] dst0, dst1;
        logic we0, we1, done;
        vliwPkg::aluOpT op0;
        vliwPkg::memOpT op1;
        int pc, nextPc, steps, i;
        wantOut.delete();
        for (i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        pc = 0;
        steps = 0;
        done = 1'b0;
        while (!done && steps < 1000 && pc < prog.size()) begin
            s0 = prog[pc][31:0];
            s1 = prog[pc][63:32];
            op0 = vliwPkg::aluOpT'(s0[31:26]);
            op1 = vliwPkg::memOpT'(s1[31:26]);
            va = regs[s0[25:21]];
            vb = regs[s0[20:16]];
            vBase = regs[s1[25:21]];
            vData = regs[s1[20:16]];
            imm0 = {{16{s0[15]}}, s0[15:0]};
            addr = vBase + {{16{s1[15]}}, s1[15:0]};
            we0 = 1'b1;
            dst0 = s0[15:11];
            res0 = '0;
            nextPc = pc + 1;
            case (op0)
                vliwPkg::aluAdd: res0 = va + vb;
                vliwPkg::aluSub: res0 = va - vb;
                vliwPkg::aluAnd: res0 = va & vb;
                vliwPkg::aluOr: res0 = va | vb;
                vliwPkg::aluAddi: begin
                    dst0 = s0[20:16];
                    res0 = va + imm0;
                end
                default: we0 = 1'b0;
            endcase
            if (op0 == vliwPkg::aluBeq && va == vb) begin
                nextPc = pc + 1 + imm0;
            end
            if (op0 == vliwPkg::aluJmp) begin
                nextPc = s0[15:0];
                done = (nextPc == pc);
            end
            if (op0 == vliwPkg::aluOut) begin
                wantOut.push_back(vb);
            end
            we1 = (op1 == vliwPkg::memLw);
            dst1 = s1[20:16];
            res1 = dmem[addr[7:0]];
            if (op1 == vliwPkg::memSw) begin
                dmem[addr[7:0]] = vData;
            end
            if (we0 && dst0 != 0) begin
                regs[dst0] = res0;
            end
            // slot 1 written last
            if (we1 && dst1 != 0) begin
                regs[dst1] = res1;
            end
            pc = nextPc;
            steps++;
        end
    endtask

    task automatic runUntil(input string name, input int want);
        int cycles;
        @(posedge clk);
        #2;
        run = 1'b1;
        cycles = 0;
        while (gotOut.size() < want && cycles < 500) begin
            @(negedge clk);
            if (outValid === 1'b1) begin
                gotOut.push_back(outData);
            end
            cycles++;
        end
        if (gotOut.size() < want) begin
            $display("%s: only %0d of %0d outputs arrived within 500 cycles",
                     name, gotOut.size(), want);
            timedOut = 1'b1;
        end
    endtask

    // catches outputs beyond the expected ones
    task automatic settle();
        int i;
        for (i = 0; i < 10; i++) begin
            @(negedge clk);
            if (outValid === 1'b1) begin
                gotOut.push_back(outData);
            end
        end
        @(posedge clk);
        #2;
        run = 1'b0;
    endtask

    task automatic compareAndReport(input string name);
        int i;
        checkValue(name, wantOut.size(), gotOut.size());
        for (i = 0; i < wantOut.size() && i < gotOut.size(); i++) begin
            checkValue(name, wantOut[i], gotOut[i]);
        end
        $display("%s finished with %0d errors", name, errors - testStartErrors);
    endtask

    task automatic runProgram(input string name);
        finishProgram();
        loadProgram();
        modelRun();
        runUntil(name, wantOut.size());
        settle();
        compareAndReport(name);
    endtask

    task automatic aluForwardTest();
        int r;
        startTest();
        emit(idleMem, makeI(vliwPkg::aluAddi, 0, 1, -3));
        emit(idleMem, makeR(vliwPkg::aluAdd, 1, 1, 2));
        emit(idleMem, makeR(vliwPkg::aluSub, 2, 1, 3));
        emit(idleMem, makeR(vliwPkg::aluAnd, 3, 2, 4));
        emit(idleMem, makeR(vliwPkg::aluOr, 4, 1, 5));
        for (r = 1; r <= 5; r++) begin
            emit(idleMem, makeR(vliwPkg::aluOut, 0, r, 0));
        end
        emit(idleMem, makeI(vliwPkg::aluAddi, 5, 6, 16'h0123));
        emit(idleMem, makeR(vliwPkg::aluOut, 0, 6, 0));
        emit(idleMem, makeR(vliwPkg::aluSub, 6, 2, 7));
        emit(idleMem, makeR(vliwPkg::aluOut, 0, 7, 0));
        runProgram("aluForward");
    endtask

    task automatic memSlotTest();
        startTest();
        emit(idleMem, makeI(vliwPkg::aluAddi, 0, 1, 100));
        emit(idleMem, makeI(vliwPkg::aluAddi, 0, 2, 16'h55));
        emit(makeI(vliwPkg::memSw, 1, 2, 4), makeI(vliwPkg::aluAddi, 0, 3, 8));
        emit(makeI(vliwPkg::memLw, 1, 5, 4), makeR(vliwPkg::aluAdd, 2, 3, 4));
        emit(idleMem, makeR(vliwPkg::aluOut, 0, 5, 0));
        // both slots target r6
        emit(makeI(vliwPkg::memLw, 1, 6, 4), makeI(vliwPkg::aluAddi, 0, 6, 1));
        emit(idleMem, makeR(vliwPkg::aluOut, 0, 6, 0));
        emit(makeI(vliwPkg::memSw, 0, 4, 7), makeR(vliwPkg::aluOut, 0, 4, 0));
        emit(makeI(vliwPkg::memLw, 0, 8, 7), idleAlu);
        emit(idleMem, makeR(vliwPkg::aluOut, 0, 8, 0));
        emit(idleMem, makeR(vliwPkg::aluOut, 0, 6, 0));
        runProgram("memSlot");
    endtask

    task automatic branchTest();
        startTest();
        emit(idleMem, makeI(vliwPkg::aluAddi, 0, 1, 3));
        emit(idleMem, makeI(vliwPkg::aluAddi, 0, 2, 3));
        emit(makeI(vliwPkg::memSw, 0, 1, 20), makeI(vliwPkg::aluBeq, 1, 2, 2));
        emit(idleMem, makeR(vliwPkg::aluOut, 0, 1, 0));
        emit(idleMem, makeR(vliwPkg::aluOut, 0, 2, 0));
        emit(idleMem, makeI(vliwPkg::aluBeq, 1, 0, 5));
        emit(makeI(vliwPkg::memLw, 0, 3, 20), makeI(vliwPkg::aluAddi, 0, 4, 9));
        emit(idleMem, makeR(vliwPkg::aluOut, 0, 3, 0));
        emit(idleMem, makeI(vliwPkg::aluJmp, 0, 0, 11));
        emit(idleMem, makeR(vliwPkg::aluOut, 0, 1, 0));
        emit(idleMem, makeR(vliwPkg::aluOut, 0, 2, 0));
        emit(idleMem, makeR(vliwPkg::aluOut, 0, 4, 0));
        // countdown loop at 13..16
        emit(idleMem, makeI(vliwPkg::aluAddi, 0, 5, 2));
        emit(idleMem, makeI(vliwPkg::aluAddi, 5, 5, -1));
        emit(idleMem, makeR(vliwPkg::aluOut, 0, 5, 0));
        emit(idleMem, makeI(vliwPkg::aluBeq, 5, 0, 1));
        emit(idleMem, makeI(vliwPkg::aluJmp, 0, 0, 13));
        emit(idleMem, makeR(vliwPkg::aluOut, 0, 4, 0));
        runProgram("branch");
    endtask

    task automatic regZeroTest();
        startTest();
        emit(idleMem, makeI(vliwPkg::aluAddi, 0, 0, 42));
        emit(idleMem, makeR(vliwPkg::aluOut, 0, 0, 0));
        emit(idleMem, makeI(vliwPkg::aluAddi, 0, 1, 7));
        emit(idleMem, makeR(vliwPkg::aluAdd, 1, 1, 0));
        emit(idleMem, makeR(vliwPkg::aluOut, 0, 0, 0));
        emit(idleMem, makeR(vliwPkg::aluOut, 0, 1, 0));
        runProgram("regZero");
    endtask

    task automatic randomImmTest();
        int i;
        logic [31:0] rnd;
        startTest();
        seed = 907;
        for (i = 0; i < 12; i++) begin
            rnd = $random(seed);
            emit(idleMem, makeI(vliwPkg::aluAddi, 1, 1, rnd[15:0]));
            emit(idleMem, makeR(vliwPkg::aluOut, 0, 1, 0));
        end
        runProgram("randomImm");
    endtask

    task automatic runHoldTest();
        int i;
        startTest();
        emit(idleMem, makeI(vliwPkg::aluAddi, 0, 1, 1));
        emit(idleMem, makeR(vliwPkg::aluOut, 0, 1, 0));
        for (i = 0; i < 7; i++) begin
            emit(idleMem, makeI(vliwPkg::aluAddi, 1, 1, 3));
            emit(idleMem, makeR(vliwPkg::aluOut, 0, 1, 0));
        end
        finishProgram();
        loadProgram();
        modelRun();
        runUntil("runHold", 3);
        @(posedge clk);
        #2;
        run = 1'b0;
        // bundles already past fetch still finish
        for (i = 0; i < 4; i++) begin
            @(negedge clk);
            if (outValid === 1'b1) begin
                gotOut.push_back(outData);
            end
        end
        for (i = 0; i < 20; i++) begin
            @(negedge clk);
            if (outValid === 1'b1) begin
                errors++;
                $display("runHold: outValid went high while run was held low");
            end
        end
        runUntil("runHold", wantOut.size());
        settle();
        compareAndReport("runHold");
    endtask

    initial begin
        resetReq = 1'b0;
        run = 1'b0;
        imemWe = 1'b0;
        imemAddr = '0;
        imemData = '0;
        errors = 0;
        checks = 0;
        tests = 0;
        timedOut = 1'b0;
        @(posedge clk);
        #2;
        aluForwardTest();
        memSlotTest();
        branchTest();
        regZeroTest();
        randomImmTest();
        runHoldTest();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0 && !timedOut) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: src/dataMem.sv
module dataMem #(
    parameter int dmemDepth = 256
) (
    input logic clk,
    memIf.rcv mem
);

    logic [vliwPkg::dataWidth-1:0] words [dmemDepth];

    always_ff @(posedge clk) begin
        if (mem.we) begin
            words[mem.addr[$clog2(dmemDepth)-1:0]] <= mem.wdata;
        end
    end

    // word address, upper bits ignored
    assign mem.rdata = words[mem.addr[$clog2(dmemDepth)-1:0]];

endmodule

// File: src/decodeUnit.sv
module decodeUnit (
    input  logic clk,
    input  logic rstn,
    input  logic [vliwPkg::bundleWidth-1:0] bundleD,
    input  logic [vliwPkg::dataWidth-1:0] pcPlusD,
    input  logic branchTaken,
    wbIf.rcv wb,
    exBundleIf.drv ex
);

    localparam int extWidth = vliwPkg::dataWidth - vliwPkg::immWidth;

    logic [vliwPkg::slotWidth-1:0] slot0;
    logic [vliwPkg::slotWidth-1:0] slot1;
    logic [vliwPkg::regAddrWidth-1:0] a0, b0, c0, a1, b1;
    logic [vliwPkg::immWidth-1:0] imm0, imm1;
    vliwPkg::aluOpT op0;
    vliwPkg::memOpT op1;
    logic [3:0][vliwPkg::regAddrWidth-1:0] rdAddr;
    logic [3:0][vliwPkg::dataWidth-1:0] rdData;

    function automatic vliwPkg::aluOpT toAluOp(input logic [5:0] code);
        vliwPkg::aluOpT op;
        op = vliwPkg::aluOpT'(code);
        case (op)
            vliwPkg::aluAdd, vliwPkg::aluSub, vliwPkg::aluAnd, vliwPkg::aluOr,
            vliwPkg::aluAddi, vliwPkg::aluBeq, vliwPkg::aluJmp, vliwPkg::aluOut: return op;
            default: return vliwPkg::aluNop;
        endcase
    endfunction

    function automatic vliwPkg::memOpT toMemOp(input logic [5:0] code);
        vliwPkg::memOpT op;
        op = vliwPkg::memOpT'(code);
        case (op)
            vliwPkg::memLw, vliwPkg::memSw: return op;
            default: return vliwPkg::memNop;
        endcase
    endfunction

    assign slot0 = bundleD[vliwPkg::slotWidth-1:0];
    assign slot1 = bundleD[vliwPkg::bundleWidth-1:vliwPkg::slotWidth];
    assign op0 = toAluOp(slot0[vliwPkg::opMsb:vliwPkg::opLsb]);
    assign op1 = toMemOp(slot1[vliwPkg::opMsb:vliwPkg::opLsb]);
    assign a0 = slot0[vliwPkg::aMsb:vliwPkg::aLsb];
    assign b0 = slot0[vliwPkg::bMsb:vliwPkg::bLsb];
    assign c0 = slot0[vliwPkg::cMsb:vliwPkg::cLsb];
    assign a1 = slot1[vliwPkg::aMsb:vliwPkg::aLsb];
    assign b1 = slot1[vliwPkg::bMsb:vliwPkg::bLsb];
    assign imm0 = slot0[vliwPkg::immMsb:vliwPkg::immLsb];
    assign imm1 = slot1[vliwPkg::immMsb:vliwPkg::immLsb];

    assign rdAddr = {b1, a1, b0, a0};

    regFile regFile0 (
        .clk    (clk),
        .rstn   (rstn),
        .rdAddr (rdAddr),
        .rdData (rdData),
        .wb     (wb)
    );

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ex.aluOp <= vliwPkg::aluNop;
            ex.memOp <= vliwPkg::memNop;
        end else if (branchTaken) begin
            ex.aluOp <= vliwPkg::aluNop;
            ex.memOp <= vliwPkg::memNop;
        end else begin
            ex.aluOp <= op0;
            ex.memOp <= op1;
        end
    end

    always_ff @(posedge clk) begin
        // addi writes field b, register ops write field c
        ex.aluDst <= (op0 == vliwPkg::aluAddi) ? b0 : c0;
        ex.aluA <= a0;
        ex.aluB <= b0;
        ex.aluAVal <= rdData[0];
        ex.aluBVal <= rdData[1];
        // jmp target is zero-extended
        if (op0 == vliwPkg::aluJmp) begin
            ex.aluImm <= {{extWidth{1'b0}}, imm0};
        end else begin
            ex.aluImm <= {{extWidth{imm0[vliwPkg::immWidth-1]}}, imm0};
        end
        ex.pcPlus <= pcPlusD;
        ex.memBase <= a1;
        ex.memData <= b1;
        ex.memBaseVal <= rdData[2];
        ex.memDataVal <= rdData[3];
        ex.memImm <= {{extWidth{imm1[vliwPkg::immWidth-1]}}, imm1};
    end

endmodule

// File: src/executeUnit.sv
module executeUnit (
    input  logic clk,
    input  logic rstn,
    exBundleIf.rcv ex,
    wbIf.drv wb,
    memIf.drv mem,
    output logic branchTaken,
    output logic [vliwPkg::dataWidth-1:0] branchTarget,
    output logic outValid,
    output logic [vliwPkg::dataWidth-1:0] outData
);

    // operand order: alu a, alu b, mem base, mem data
    logic [3:0][vliwPkg::regAddrWidth-1:0] srcIdx;
    logic [3:0][vliwPkg::dataWidth-1:0] srcVal;
    logic [3:0][vliwPkg::dataWidth-1:0] fwdVal;
    logic [vliwPkg::dataWidth-1:0] aluRes;
    logic [vliwPkg::dataWidth-1:0] memAddr;
    logic aluWe;

    assign srcIdx = {ex.memData, ex.memBase, ex.aluB, ex.aluA};
    assign srcVal = {ex.memDataVal, ex.memBaseVal, ex.aluBVal, ex.aluAVal};

    // bypass from the memory stage, slot 1 over slot 0
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            fwdVal[i] = srcVal[i];
            if (wb.we0 && wb.addr0 == srcIdx[i] && srcIdx[i] != '0) begin
                fwdVal[i] = wb.data0;
            end
            if (wb.we1 && wb.addr1 == srcIdx[i] && srcIdx[i] != '0) begin
                fwdVal[i] = wb.data1;
            end
        end
    end

    always_comb begin
        aluWe = 1'b1;
        case (ex.aluOp)
            vliwPkg::aluAdd: aluRes = fwdVal[0] + fwdVal[1];
            vliwPkg::aluSub: aluRes = fwdVal[0] - fwdVal[1];
            vliwPkg::aluAnd: aluRes = fwdVal[0] & fwdVal[1];
            vliwPkg::aluOr: aluRes = fwdVal[0] | fwdVal[1];
            vliwPkg::aluAddi: aluRes = fwdVal[0] + ex.aluImm;
            default: begin
                aluRes = '0;
                aluWe = 1'b0;
            end
        endcase
    end

    assign branchTaken = (ex.aluOp == vliwPkg::aluJmp)
                      || (ex.aluOp == vliwPkg::aluBeq && fwdVal[0] == fwdVal[1]);
    assign branchTarget = (ex.aluOp == vliwPkg::aluJmp) ? ex.aluImm : ex.pcPlus + ex.aluImm;

    assign outValid = (ex.aluOp == vliwPkg::aluOut);
    assign outData = fwdVal[1];

    assign memAddr = fwdVal[2] + ex.memImm;

    // execute-to-memory register, its outputs are the memory stage
    always_ff @(posedge clk) begin
        if (!rstn) begin
            wb.we0 <= 1'b0;
            wb.we1 <= 1'b0;
            mem.we <= 1'b0;
        end else begin
            wb.we0 <= aluWe;
            wb.we1 <= (ex.memOp == vliwPkg::memLw);
            mem.we <= (ex.memOp == vliwPkg::memSw);
        end
    end

    always_ff @(posedge clk) begin
        wb.addr0 <= ex.aluDst;
        wb.data0 <= aluRes;
        wb.addr1 <= ex.memData;
        mem.addr <= memAddr;
        mem.wdata <= fwdVal[3];
    end

    // load data goes straight back on port 1
    assign wb.data1 = mem.rdata;

endmodule

// File: src/fetchUnit.sv
module fetchUnit (
    input  logic clk,
    input  logic rstn,
    input  logic run,
    input  logic branchTaken,
    input  logic [vliwPkg::dataWidth-1:0] branchTarget,
    input  logic [vliwPkg::bundleWidth-1:0] bundle,
    output logic [vliwPkg::dataWidth-1:0] pc,
    output logic [vliwPkg::bundleWidth-1:0] bundleD,
    output logic [vliwPkg::dataWidth-1:0] pcPlusD
);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pc <= '0;
            bundleD <= vliwPkg::nopBundle;
        end else begin
            if (branchTaken) begin
                pc <= branchTarget;
            end else if (run) begin
                pc <= pc + 1'b1;
            end
            // flushed or held bundles become bubbles
            if (branchTaken || !run) begin
                bundleD <= vliwPkg::nopBundle;
            end else begin
                bundleD <= bundle;
            end
        end
    end

    always_ff @(posedge clk) begin
        pcPlusD <= pc + 1'b1;
    end

endmodule

// File: src/instrMem.sv
module instrMem #(
    parameter int imemDepth = 256
) (
    input  logic clk,
    input  logic imemWe,
    input  logic [$clog2(imemDepth)-1:0] imemAddr,
    input  logic [vliwPkg::bundleWidth-1:0] imemData,
    input  logic [vliwPkg::dataWidth-1:0] rdAddr,
    output logic [vliwPkg::bundleWidth-1:0] bundle
);

    logic [vliwPkg::bundleWidth-1:0] bundles [imemDepth];

    // loaded from the top ports while the core is held
    always_ff @(posedge clk) begin
        if (imemWe) begin
            bundles[imemAddr] <= imemData;
        end
    end

    // pc wraps on the low bits
    assign bundle = bundles[rdAddr[$clog2(imemDepth)-1:0]];

endmodule

// File: src/regFile.sv
module regFile (
    input  logic clk,
    input  logic rstn,
    input  logic [3:0][vliwPkg::regAddrWidth-1:0] rdAddr,
    output logic [3:0][vliwPkg::dataWidth-1:0] rdData,
    wbIf.rcv wb
);

    logic [vliwPkg::dataWidth-1:0] regs [2**vliwPkg::regAddrWidth];

    // r0 is never written, so it reads zero
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < 2**vliwPkg::regAddrWidth; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wb.we0 && wb.addr0 != '0) begin
                regs[wb.addr0] <= wb.data0;
            end
            if (wb.we1 && wb.addr1 != '0) begin
                regs[wb.addr1] <= wb.data1;
            end
        end
    end

    // write-through, slot 1 checked last so it wins
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            rdData[i] = regs[rdAddr[i]];
            if (wb.we0 && wb.addr0 == rdAddr[i] && rdAddr[i] != '0) begin
                rdData[i] = wb.data0;
            end
            if (wb.we1 && wb.addr1 == rdAddr[i] && rdAddr[i] != '0) begin
                rdData[i] = wb.data1;
            end
        end
    end

endmodule

// File: src/vliwCore.sv
module vliwCore #(
    parameter int imemDepth = 256,
    parameter int dmemDepth = 256
) (
    input  logic clk,
    input  logic rstn,
    input  logic run,
    input  logic imemWe,
    input  logic [$clog2(imemDepth)-1:0] imemAddr,
    input  logic [vliwPkg::bundleWidth-1:0] imemData,
    output logic outValid,
    output logic [vliwPkg::dataWidth-1:0] outData
);

    logic [vliwPkg::dataWidth-1:0] pc;
    logic [vliwPkg::bundleWidth-1:0] bundle;
    logic [vliwPkg::bundleWidth-1:0] bundleD;
    logic [vliwPkg::dataWidth-1:0] pcPlusD;
    logic branchTaken;
    logic [vliwPkg::dataWidth-1:0] branchTarget;

    exBundleIf exBus ();
    wbIf wbBus ();
    memIf memBus ();

    instrMem #(.imemDepth(imemDepth)) instrMem0 (
        .clk      (clk),
        .imemWe   (imemWe),
        .imemAddr (imemAddr),
        .imemData (imemData),
        .rdAddr   (pc),
        .bundle   (bundle)
    );

    fetchUnit fetchUnit0 (
        .clk          (clk),
        .rstn         (rstn),
        .run          (run),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .bundle       (bundle),
        .pc           (pc),
        .bundleD      (bundleD),
        .pcPlusD      (pcPlusD)
    );

    decodeUnit decodeUnit0 (
        .clk         (clk),
        .rstn        (rstn),
        .bundleD     (bundleD),
        .pcPlusD     (pcPlusD),
        .branchTaken (branchTaken),
        .wb          (wbBus),
        .ex          (exBus)
    );

    executeUnit executeUnit0 (
        .clk          (clk),
        .rstn         (rstn),
        .ex           (exBus),
        .wb           (wbBus),
        .mem          (memBus),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .outValid     (outValid),
        .outData      (outData)
    );

    dataMem #(.dmemDepth(dmemDepth)) dataMem0 (
        .clk (clk),
        .mem (memBus)
    );

endmodule

// File: src/vliwIf.sv
interface exBundleIf;
    vliwPkg::aluOpT aluOp;
    logic [vliwPkg::regAddrWidth-1:0] aluDst;
    logic [vliwPkg::regAddrWidth-1:0] aluA;
    logic [vliwPkg::regAddrWidth-1:0] aluB;
    logic [vliwPkg::dataWidth-1:0] aluAVal;
    logic [vliwPkg::dataWidth-1:0] aluBVal;
    logic [vliwPkg::dataWidth-1:0] aluImm;
    logic [vliwPkg::dataWidth-1:0] pcPlus;
    vliwPkg::memOpT memOp;
    logic [vliwPkg::regAddrWidth-1:0] memBase;
    logic [vliwPkg::regAddrWidth-1:0] memData;
    logic [vliwPkg::dataWidth-1:0] memBaseVal;
    logic [vliwPkg::dataWidth-1:0] memDataVal;
    logic [vliwPkg::dataWidth-1:0] memImm;

    modport drv (output aluOp, aluDst, aluA, aluB, aluAVal, aluBVal, aluImm, pcPlus,
                 output memOp, memBase, memData, memBaseVal, memDataVal, memImm);
    modport rcv (input aluOp, aluDst, aluA, aluB, aluAVal, aluBVal, aluImm, pcPlus,
                 input memOp, memBase, memData, memBaseVal, memDataVal, memImm);
endinterface

interface wbIf;
    logic we0;
    logic [vliwPkg::regAddrWidth-1:0] addr0;
    logic [vliwPkg::dataWidth-1:0] data0;
    logic we1;
    logic [vliwPkg::regAddrWidth-1:0] addr1;
    logic [vliwPkg::dataWidth-1:0] data1;

    modport drv (output we0, addr0, data0, we1, addr1, data1);
    modport rcv (input we0, addr0, data0, we1, addr1, data1);
endinterface

interface memIf;
    logic we;
    logic [vliwPkg::dataWidth-1:0] addr;
    logic [vliwPkg::dataWidth-1:0] wdata;
    logic [vliwPkg::dataWidth-1:0] rdata;

    modport drv (output we, addr, wdata, input rdata);
    modport rcv (input we, addr, wdata, output rdata);
endinterface

// File: src/vliwPkg.sv
package vliwPkg;

    localparam int dataWidth = 32;
    localparam int bundleWidth = 64;
    localparam int slotWidth = 32;
    localparam int regAddrWidth = 5;
    localparam int immWidth = 16;

    // field positions inside one 32-bit slot
    localparam int opMsb = 31;
    localparam int opLsb = 26;
    localparam int aMsb = 25;
    localparam int aLsb = 21;
    localparam int bMsb = 20;
    localparam int bLsb = 16;
    localparam int cMsb = 15;
    localparam int cLsb = 11;
    localparam int immMsb = 15;
    localparam int immLsb = 0;

    // slot 0, alu and control
    typedef enum logic [5:0] {
        aluAdd  = 6'h01,
        aluSub  = 6'h02,
        aluAnd  = 6'h03,
        aluOr   = 6'h04,
        aluAddi = 6'h08,
        aluBeq  = 6'h10,
        aluJmp  = 6'h11,
        aluOut  = 6'h18,
        aluNop  = 6'h1f
    } aluOpT;

    // slot 1, memory
    typedef enum logic [5:0] {
        memLw  = 6'h23,
        memSw  = 6'h2b,
        memNop = 6'h1f
    } memOpT;

    // slot 1 sits in the upper half
    localparam logic [bundleWidth-1:0] nopBundle = {memNop, 26'd0, aluNop, 26'd0};

endpackage
